// ==== tb.f ====
+incdir+tests
logic/pers_pkg.sv
logic/inst_decode.sv
logic/aeg_file.sv
logic/launch_ctrl.sv
logic/pe_stage.sv
logic/cae_pers.sv
tests/tb_cae_pers.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cae_pers -f tb.f || exit 1
out=$(./obj_dir/Vtb_cae_pers 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

// ==== tests/tb_util.svh ====
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// ***********************************************************************
// random numbers and expected words
// ***********************************************************************

function logic [31:0] lfsr_step(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// one LFSR step per bit taken
function logic [63:0] rand_bits(input int n);
   logic [63:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
   end
   return v;
endfunction

// class on top, index or caep number in the low bits
function pers_pkg::dispatch_inst_u build_inst(input logic [pers_pkg::CLASS_W-1:0] cls,
                                              input logic [24:0] field);
   return {cls, field};
endfunction

function pers_pkg::chain_word_t count_word(input logic [pers_pkg::PE_ID_W-1:0] pe,
                                           input logic [pers_pkg::ARG_W-1:0] arg);
   return '{arg: arg, pe_id: pe, opcode: pers_pkg::OP_COUNT};
endfunction

// stages 0 to pe each add one on the way
function pers_pkg::chain_word_t returned_word(input logic [pers_pkg::PE_ID_W-1:0] pe,
                                              input logic [pers_pkg::ARG_W-1:0] arg);
   return '{arg: arg + pers_pkg::ARG_W'(pe) + 1'b1, pe_id: pe, opcode: pers_pkg::OP_RETURN};
endfunction

// ***********************************************************************
// host instructions, called on a falling edge
// ***********************************************************************

task issue_inst(input pers_pkg::dispatch_inst_u inst, input logic [63:0] data,
                input expect_t resp);
   cae_inst     = inst;
   cae_data     = data;
   cae_inst_vld = 1'b1;
   @(negedge clk);
   cae_inst_vld = 1'b0;
   expected     = resp;
   @(negedge clk);
   expected     = '0;
endtask

task aeg_access(input logic wr, input logic [pers_pkg::AEG_IDX_W-1:0] idx,
                input logic [63:0] data);
   expect_t resp;
   resp = '0;
   if (idx >= pers_pkg::AEG_IDX_W'(pers_pkg::NUM_AEG)) begin
      resp.exc[pers_pkg::EXC_AEGIDX] = 1'b1;
   end else if (wr) begin
      exp_aeg[idx[pers_pkg::AEG_SEL_W-1:0]] = data;
   end else begin
      resp.ret_vld  = 1'b1;
      resp.ret_data = exp_aeg[idx[pers_pkg::AEG_SEL_W-1:0]];
   end
   issue_inst(build_inst(wr ? pers_pkg::CLASS_AEG_WR : pers_pkg::CLASS_AEG_RD, 25'(idx)),
              data, resp);
endtask

task caep_op(input logic [pers_pkg::CAEP_W-1:0] caep);
   expect_t resp;
   resp = '0;
   resp.exc[pers_pkg::EXC_UNIMPL] = caep != pers_pkg::CAEP_NOP && caep != pers_pkg::CAEP_LAUNCH;
   issue_inst(build_inst(pers_pkg::CLASS_CAEP, 25'(caep)), '0, resp);
endtask

task launch_run();
   int waited;
   run_active = 1'b1;
   caep_op(pers_pkg::CAEP_LAUNCH);
   waited = 0;
   while (cae_stall) begin
      if (waited > STALL_LIMIT) begin
         plain_failure("stall is still high long after the launch");
      end
      @(negedge clk);
      waited++;
   end
   run_active = 1'b0;
endtask

`endif

// ==== tests/tb_cae_pers.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cae_pers;

   localparam int CLK_PERIOD      = 10;
   localparam int ROUNDS          = 2;
   localparam int LAUNCHES        = 4;
   localparam int HOST_OPS        = ROUNDS * 4 + 6 + 7 + LAUNCHES * 3 + 2;
   localparam int STALL_LIMIT     = pers_pkg::MIN_BUSY + pers_pkg::PE_COUNT + 8;
   localparam int RUN_CYCLES      = 10 + HOST_OPS * 2 + (LAUNCHES + 1) * (STALL_LIMIT + 2);
   localparam int WATCHDOG_CYCLES = RUN_CYCLES + 200;

   typedef struct packed {
      logic                         ret_vld;
      logic [pers_pkg::DATA_W-1:0]  ret_data;
      logic [pers_pkg::EXC_W-1:0]   exc;
   } expect_t;

   logic                             clk;
   logic                             reset_per;
   pers_pkg::dispatch_inst_u         cae_inst;
   logic [pers_pkg::DATA_W-1:0]      cae_data;
   logic                             cae_inst_vld;
   logic [pers_pkg::AEG_IDX_W-1:0]   cae_aeg_cnt;
   logic [pers_pkg::EXC_W-1:0]       cae_exception;
   logic [pers_pkg::DATA_W-1:0]      cae_ret_data;
   logic                             cae_ret_data_vld;
   logic                             cae_idle;
   logic                             cae_stall;

   expect_t                          expected;
   logic [pers_pkg::DATA_W-1:0]      exp_aeg [pers_pkg::NUM_AEG];
   logic                             run_active;
   int                               launch_age = 0;
   logic [31:0]                      lfsr_state = 32'haae780e5;

   cae_pers i_cae_pers (
      .clk                (clk),
      .reset_per          (reset_per),
      .cae_inst_i         (cae_inst),
      .cae_data_i         (cae_data),
      .cae_inst_vld_i     (cae_inst_vld),
      .cae_aeg_cnt_o      (cae_aeg_cnt),
      .cae_exception_o    (cae_exception),
      .cae_ret_data_o     (cae_ret_data),
      .cae_ret_data_vld_o (cae_ret_data_vld),
      .cae_idle_o         (cae_idle),
      .cae_stall_o        (cae_stall)
   );

   task stop_failed();
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task value_mismatch(input string name, input logic [63:0] expv, input logic [63:0] actv);
      $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expv, actv);
      stop_failed();
   endtask

   task plain_failure(input string why);
      $display("failure at %0t ns: %s", $time, why);
      stop_failed();
   endtask

   `include "tb_util.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      plain_failure("watchdog expired before the tests finished");
   end

   // cycles since the launch instruction went out
   always @(posedge clk) begin
      if (!run_active) begin
         launch_age <= 0;
      end else begin
         launch_age <= launch_age + 1;
      end
   end

   // ***********************************************************************
   // checks
   // ***********************************************************************

   assert property (@(posedge clk) disable iff (reset_per) cae_ret_data_vld == expected.ret_vld)
      else value_mismatch("cae_ret_data_vld_o", 64'(expected.ret_vld),
                          64'($sampled(cae_ret_data_vld)));

   assert property (@(posedge clk) disable iff (reset_per)
      expected.ret_vld |-> cae_ret_data == expected.ret_data)
      else value_mismatch("cae_ret_data_o", expected.ret_data, $sampled(cae_ret_data));

   assert property (@(posedge clk) disable iff (reset_per) cae_exception == expected.exc)
      else value_mismatch("cae_exception_o", 64'(expected.exc), 64'($sampled(cae_exception)));

   // launch cycle plus the whole minimum window
   assert property (@(posedge clk) disable iff (reset_per)
      (run_active && launch_age <= pers_pkg::MIN_BUSY) |-> cae_stall)
      else value_mismatch("cae_stall_o", 64'(1), 64'($sampled(cae_stall)));

   assert property (@(posedge clk) disable iff (reset_per)
      (run_active && launch_age <= pers_pkg::MIN_BUSY) |-> !cae_idle)
      else value_mismatch("cae_idle_o", 64'(0), 64'($sampled(cae_idle)));

   assert property (@(posedge clk) disable iff (reset_per) !run_active |-> !cae_stall)
      else value_mismatch("cae_stall_o", 64'(0), 64'($sampled(cae_stall)));

   assert property (@(posedge clk) disable iff (reset_per) !run_active |-> cae_idle)
      else value_mismatch("cae_idle_o", 64'(1), 64'($sampled(cae_idle)));

   assert property (@(posedge clk) disable iff (reset_per)
      cae_aeg_cnt == pers_pkg::AEG_IDX_W'(pers_pkg::NUM_AEG))
      else value_mismatch("cae_aeg_cnt_o", 64'(pers_pkg::NUM_AEG), 64'($sampled(cae_aeg_cnt)));

   // ***********************************************************************
   // stimulus
   // ***********************************************************************

   initial begin
      logic [pers_pkg::PE_ID_W-1:0]   pe;
      logic [pers_pkg::ARG_W-1:0]     arg;
      logic [pers_pkg::CLASS_W-1:0]   cls;
      logic [pers_pkg::CAEP_W-1:0]    caep;
      logic [pers_pkg::AEG_IDX_W-1:0] idx;
      expect_t                        resp;
      cae_inst     = '0;
      cae_data     = '0;
      cae_inst_vld = 1'b0;
      reset_per    = 1'b1;
      run_active   = 1'b0;
      expected     = '0;
      repeat (3) @(negedge clk);
      reset_per = 1'b0;
      repeat (4) @(negedge clk);

      for (int r = 0; r < ROUNDS; r++) begin
         for (int i = 0; i < pers_pkg::NUM_AEG; i++) begin
            aeg_access(1'b1, pers_pkg::AEG_IDX_W'(i), rand_bits(64));
         end
         for (int i = 0; i < pers_pkg::NUM_AEG; i++) begin
            aeg_access(1'b0, pers_pkg::AEG_IDX_W'(i), '0);
         end
      end

      // bad index, then both registers must be unchanged
      idx = pers_pkg::AEG_IDX_W'(rand_bits(16)) + pers_pkg::AEG_IDX_W'(pers_pkg::NUM_AEG);
      aeg_access(1'b1, pers_pkg::AEG_IDX_W'(pers_pkg::NUM_AEG), rand_bits(64));
      aeg_access(1'b1, idx, rand_bits(64));
      aeg_access(1'b0, pers_pkg::AEG_IDX_W'(pers_pkg::NUM_AEG), '0);
      aeg_access(1'b0, idx, '0);
      aeg_access(1'b0, '0, '0);
      aeg_access(1'b0, pers_pkg::AEG_IDX_W'(1), '0);

      resp = '0;
      resp.exc[pers_pkg::EXC_UNIMPL] = 1'b1;
      for (int i = 0; i < 3; i++) begin
         cls = pers_pkg::CLASS_W'(rand_bits(7));
         if (cls == pers_pkg::CLASS_AEG_WR || cls == pers_pkg::CLASS_AEG_RD ||
             cls == pers_pkg::CLASS_CAEP) begin
            cls = cls ^ 7'h01;
         end
         issue_inst(build_inst(cls, 25'(rand_bits(25))), '0, resp);
      end
      for (int i = 0; i < 3; i++) begin
         caep = pers_pkg::CAEP_W'(rand_bits(5));
         if (caep < 5'd2) begin
            caep = caep + 5'd2;
         end
         caep_op(caep);
      end
      caep_op(pers_pkg::CAEP_NOP);

      for (int i = 0; i < LAUNCHES; i++) begin
         pe  = pers_pkg::PE_ID_W'(rand_bits($clog2(pers_pkg::PE_COUNT)));
         arg = pers_pkg::ARG_W'(rand_bits(pers_pkg::ARG_W));
         aeg_access(1'b1, '0, count_word(pe, arg));
         launch_run();
         exp_aeg[0] = returned_word(pe, arg);
         aeg_access(1'b0, '0, '0);
         aeg_access(1'b0, pers_pkg::AEG_IDX_W'(1), '0);
      end

      // no PE claims this word, AEG 0 keeps it
      pe = pers_pkg::PE_ID_W'(rand_bits(8));
      if (pe < pers_pkg::PE_ID_W'(pers_pkg::PE_COUNT)) begin
         pe = pe + pers_pkg::PE_ID_W'(pers_pkg::PE_COUNT);
      end
      aeg_access(1'b1, '0, count_word(pe, pers_pkg::ARG_W'(rand_bits(pers_pkg::ARG_W))));
      launch_run();
      aeg_access(1'b0, '0, '0);

      repeat (3) @(negedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/cae_pers.sv ====
`timescale 1ns/1ns
`default_nettype none

module cae_pers (
   input  wire                                clk,
   input  wire                                reset_per,

   // dispatch interface
   input  wire  pers_pkg::dispatch_inst_u     cae_inst_i,
   input  wire  [pers_pkg::DATA_W-1:0]        cae_data_i,
   input  wire                                cae_inst_vld_i,

   output logic [pers_pkg::AEG_IDX_W-1:0]     cae_aeg_cnt_o,
   output logic [pers_pkg::EXC_W-1:0]         cae_exception_o,
   output logic [pers_pkg::DATA_W-1:0]        cae_ret_data_o,
   output logic                               cae_ret_data_vld_o,
   output logic                               cae_idle_o,
   output logic                               cae_stall_o
);

   pers_pkg::dispatch_t   dispatch;
   pers_pkg::chain_word_t aeg0_word;
   pers_pkg::chain_word_t chain_word [pers_pkg::PE_COUNT+1];
   logic [pers_pkg::PE_COUNT:0] chain_busy;

   assign cae_aeg_cnt_o = pers_pkg::AEG_IDX_W'(pers_pkg::NUM_AEG);

   // ********************************************************************
   // dispatch side
   // ********************************************************************

   inst_decode i_inst_decode (
      .inst_i     (cae_inst_i),
      .inst_vld_i (cae_inst_vld_i),
      .dispatch_o (dispatch)
   );

   aeg_file i_aeg_file (
      .clk         (clk),
      .reset_per   (reset_per),
      .dispatch_i  (dispatch),
      .data_i      (cae_data_i),
      .tail_i      (chain_word[pers_pkg::PE_COUNT]),
      .aeg0_o      (aeg0_word),
      .ret_data_o  (cae_ret_data_o),
      .ret_vld_o   (cae_ret_data_vld_o),
      .exception_o (cae_exception_o)
   );

   launch_ctrl i_launch_ctrl (
      .clk          (clk),
      .reset_per    (reset_per),
      .launch_i     (dispatch.launch),
      .aeg0_i       (aeg0_word),
      .chain_busy_i (chain_busy[pers_pkg::PE_COUNT]),
      .head_o       (chain_word[0]),
      .idle_o       (cae_idle_o),
      .stall_o      (cae_stall_o)
   );

   // ********************************************************************
   // PE chain
   // ********************************************************************

   // nothing is busy ahead of the first stage
   assign chain_busy[0] = 1'b0;

   for (genvar g = 0; g < pers_pkg::PE_COUNT; g++) begin : gen_pe
      pe_stage #(
         .PE_INDEX (g)
      ) i_pe_stage (
         .clk       (clk),
         .reset_per (reset_per),
         .word_i    (chain_word[g]),
         .busy_i    (chain_busy[g]),
         .word_o    (chain_word[g+1]),
         .busy_o    (chain_busy[g+1])
      );
   end

endmodule

`default_nettype wire

// ==== logic/pe_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module pe_stage #(
   parameter int PE_INDEX = 0
) (
   input  wire                         clk,
   input  wire                         reset_per,
   input  wire  pers_pkg::chain_word_t word_i,
   input  wire                         busy_i,
   output pers_pkg::chain_word_t       word_o,
   output logic                        busy_o
);

   pers_pkg::chain_word_t word_nxt;
   pers_pkg::chain_word_t word_q;

   // count words bump their argument, the addressed PE turns them around
   always_comb begin
      word_nxt = word_i;
      if (word_i.opcode == pers_pkg::OP_COUNT) begin
         word_nxt.arg = word_i.arg + 1'b1;
         if (word_i.pe_id == pers_pkg::PE_ID_W'(PE_INDEX)) begin
            word_nxt.opcode = pers_pkg::OP_RETURN;
         end
      end
   end

   always_ff @(posedge clk) begin
      word_q <= word_nxt;
      if (reset_per) begin
         word_q.opcode <= pers_pkg::OP_NOP;
      end
   end

   assign word_o = word_q;
   assign busy_o = busy_i || (word_q.opcode != pers_pkg::OP_NOP);

   // a finished word is never counted again
   assert property (@(posedge clk) disable iff (reset_per)
      (word_i.opcode == pers_pkg::OP_RETURN) |=> (word_o.opcode != pers_pkg::OP_COUNT));

endmodule

`default_nettype wire

// ==== logic/launch_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module launch_ctrl (
   input  wire                         clk,
   input  wire                         reset_per,
   input  wire                         launch_i,
   input  wire  pers_pkg::chain_word_t aeg0_i,
   input  wire                         chain_busy_i,
   output pers_pkg::chain_word_t       head_o,
   output logic                        idle_o,
   output logic                        stall_o
);

   logic                            launch_q;
   logic [pers_pkg::BUSY_CNT_W-1:0] busy_cnt_q;
   logic                            window;
   pers_pkg::chain_word_t           head_q;

   // ********************************************************************
   // launch strobe and minimum busy window
   // ********************************************************************

   always_ff @(posedge clk) begin
      if (reset_per) begin
         launch_q <= 1'b0;
      end else begin
         launch_q <= launch_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         busy_cnt_q <= '0;
      end else if (launch_q) begin
         busy_cnt_q <= pers_pkg::BUSY_CNT_W'(pers_pkg::MIN_BUSY);
      end else if (window) begin
         busy_cnt_q <= busy_cnt_q - 1'b1;
      end
   end

   assign window = busy_cnt_q != '0;

   // ********************************************************************
   // chain injection
   // ********************************************************************

   // AEG 0 goes in for one cycle, NOP otherwise
   always_ff @(posedge clk) begin
      if (reset_per) begin
         head_q <= pers_pkg::NOP_WORD;
      end else if (launch_q) begin
         head_q <= aeg0_i;
      end else begin
         head_q <= pers_pkg::NOP_WORD;
      end
   end

   assign head_o = head_q;

   // launch_i covers the dispatch cycle itself
   assign stall_o = launch_i || launch_q || window || chain_busy_i;
   assign idle_o  = !stall_o;

   assert property (@(posedge clk) idle_o == !stall_o);

endmodule

`default_nettype wire

// ==== logic/aeg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module aeg_file (
   input  wire                           clk,
   input  wire                           reset_per,
   input  wire  pers_pkg::dispatch_t     dispatch_i,
   input  wire  [pers_pkg::DATA_W-1:0]   data_i,
   input  wire  pers_pkg::chain_word_t   tail_i,
   output pers_pkg::chain_word_t         aeg0_o,
   output logic [pers_pkg::DATA_W-1:0]   ret_data_o,
   output logic                          ret_vld_o,
   output logic [pers_pkg::EXC_W-1:0]    exception_o
);

   logic [pers_pkg::DATA_W-1:0]    aeg_q [pers_pkg::NUM_AEG];
   logic [pers_pkg::AEG_SEL_W-1:0] sel;
   logic                           idx_ok;
   logic                           wr_ok;
   logic                           rd_ok;
   logic                           ret_capture;
   logic                           ret_vld_q;
   logic [pers_pkg::DATA_W-1:0]    ret_data_q;
   logic                           unimpl_q;
   logic                           aegidx_q;

   assign idx_ok = dispatch_i.aeg_idx < pers_pkg::NUM_AEG;
   assign sel    = dispatch_i.aeg_idx[pers_pkg::AEG_SEL_W-1:0];
   assign wr_ok  = dispatch_i.aeg_wr && idx_ok;
   assign rd_ok  = dispatch_i.aeg_rd && idx_ok;

   // return word from the end of the chain
   assign ret_capture = tail_i.opcode == pers_pkg::OP_RETURN;

   // ********************************************************************
   // register file
   // ********************************************************************

   for (genvar g = 0; g < pers_pkg::NUM_AEG; g++) begin : gen_aeg
      logic capture;

      // only AEG 0 takes chain results
      assign capture = (g == 0) && ret_capture;

      always_ff @(posedge clk) begin
         if (wr_ok && sel == g) begin
            aeg_q[g] <= data_i;
         end else if (capture) begin
            aeg_q[g] <= tail_i;
         end
      end
   end

   assign aeg0_o = aeg_q[0];

   // ********************************************************************
   // read return and exceptions
   // ********************************************************************

   always_ff @(posedge clk) begin
      if (reset_per) begin
         ret_vld_q <= 1'b0;
         unimpl_q  <= 1'b0;
         aegidx_q  <= 1'b0;
      end else begin
         ret_vld_q <= rd_ok;
         unimpl_q  <= dispatch_i.unimpl;
         aegidx_q  <= (dispatch_i.aeg_wr || dispatch_i.aeg_rd) && !idx_ok;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_ok) begin
         ret_data_q <= aeg_q[sel];
      end
   end

   assign ret_vld_o  = ret_vld_q;
   assign ret_data_o = ret_data_q;

   always_comb begin
      exception_o = '0;
      exception_o[pers_pkg::EXC_UNIMPL] = unimpl_q;
      exception_o[pers_pkg::EXC_AEGIDX] = aegidx_q;
   end

   assert property (@(posedge clk) disable iff (reset_per)
      !(ret_vld_o && exception_o[pers_pkg::EXC_AEGIDX]));

endmodule

`default_nettype wire

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decode (
   input  wire  pers_pkg::dispatch_inst_u inst_i,
   input  wire                            inst_vld_i,
   output pers_pkg::dispatch_t            dispatch_o
);

   logic [pers_pkg::CLASS_W-1:0] inst_class;

   // class bits line up in both views
   assign inst_class = inst_i.aeg_view.inst_class;

   always_comb begin
      dispatch_o = '0;
      if (inst_vld_i) begin
         case (inst_class)
            pers_pkg::CLASS_AEG_WR: begin
               dispatch_o.aeg_wr  = 1'b1;
               dispatch_o.aeg_idx = inst_i.aeg_view.aeg_idx;
            end
            pers_pkg::CLASS_AEG_RD: begin
               dispatch_o.aeg_rd  = 1'b1;
               dispatch_o.aeg_idx = inst_i.aeg_view.aeg_idx;
            end
            pers_pkg::CLASS_CAEP: begin
               case (inst_i.caep_view.caep)
                  // caep 0 is accepted and does nothing
                  pers_pkg::CAEP_NOP: begin
                     dispatch_o.unimpl = 1'b0;
                  end
                  pers_pkg::CAEP_LAUNCH: begin
                     dispatch_o.launch = 1'b1;
                  end
                  default: begin
                     dispatch_o.unimpl = 1'b1;
                  end
               endcase
            end
            default: begin
               dispatch_o.unimpl = 1'b1;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/pers_pkg.sv ====
`default_nettype none

package pers_pkg;

   // ********************************************************************
   // dispatch interface
   // ********************************************************************

   localparam int INST_W    = 32;
   localparam int NUM_AEG   = 2;
   localparam int AEG_IDX_W = 18;
   localparam int AEG_SEL_W = 1;
   localparam int DATA_W    = 64;
   localparam int CAEP_W    = 5;
   localparam int CLASS_W   = 7;

   localparam logic [CLASS_W-1:0] CLASS_AEG_WR = 7'h20;
   localparam logic [CLASS_W-1:0] CLASS_AEG_RD = 7'h1c;
   localparam logic [CLASS_W-1:0] CLASS_CAEP   = 7'h68;

   localparam logic [CAEP_W-1:0] CAEP_NOP    = 5'd0;
   localparam logic [CAEP_W-1:0] CAEP_LAUNCH = 5'd1;

   localparam int EXC_W      = 16;
   localparam int EXC_UNIMPL = 0;
   localparam int EXC_AEGIDX = 1;

   // same 32 bits, two field layouts
   typedef struct packed {
      logic [CLASS_W-1:0]                  inst_class;
      logic [INST_W-CLASS_W-AEG_IDX_W-1:0] pad;
      logic [AEG_IDX_W-1:0]                aeg_idx;
   } aeg_view_t;

   typedef struct packed {
      logic [CLASS_W-1:0]               inst_class;
      logic [INST_W-CLASS_W-CAEP_W-1:0] pad;
      logic [CAEP_W-1:0]                caep;
   } caep_view_t;

   typedef union packed {
      aeg_view_t  aeg_view;
      caep_view_t caep_view;
   } dispatch_inst_u;

   typedef struct packed {
      logic                 aeg_wr;
      logic                 aeg_rd;
      logic [AEG_IDX_W-1:0] aeg_idx;
      logic                 launch;
      logic                 unimpl;
   } dispatch_t;

   // ********************************************************************
   // instruction chain
   // ********************************************************************

   localparam int PE_COUNT   = 16;
   localparam int MIN_BUSY   = 64;
   localparam int BUSY_CNT_W = $clog2(MIN_BUSY + 1);
   localparam int OP_W       = 8;
   localparam int PE_ID_W    = 8;
   localparam int ARG_W      = 48;

   localparam logic [OP_W-1:0] OP_NOP    = 8'd0;
   localparam logic [OP_W-1:0] OP_RETURN = 8'd1;
   localparam logic [OP_W-1:0] OP_COUNT  = 8'd2;

   // opcode sits in the low byte
   typedef struct packed {
      logic [ARG_W-1:0]   arg;
      logic [PE_ID_W-1:0] pe_id;
      logic [OP_W-1:0]    opcode;
   } chain_word_t;

   localparam chain_word_t NOP_WORD = '{arg: '0, pe_id: '0, opcode: OP_NOP};

endpackage

`default_nettype wire
